// ==== dv/anticTb.sv ====
// ******************************
// Each list ends in a JVB; the next load pulses vblank to release it
// ******************************
`timescale 1ns/100ps

module anticTb import anticPkg::*; ();

  localparam int clkPeriod = 40;
  localparam int totalFetches = 201;
  localparam int watchdogCycles = 3 * totalFetches + 300;

  logic        Fphi0;
  logic        rst;
  logic        dlistLoad;
  logic [15:0] dlistAddr;
  logic [7:0]  dmactl;
  logic [7:0]  chbase;
  logic        vblank;
  logic [15:0] memAddr;
  logic        memRd;
  logic [7:0]  memData;
  logic        lineStart;
  lineInfo     line;
  logic        byteOut;
  dmaByte      byteData;
  logic        dli;
  logic        dmaBusy;

  lineInfo     lineQ [$];
  lineInfo     expLines [$];
  dmaByte      byteQ [$];
  dmaByte      expBytes [$];
  logic [15:0] addrQ [$];
  logic [15:0] expAddrs [$];
  logic        prevRd;
  int          dliCount;
  int          errors;
  int          testStartErrors;
  int          testsRun;
  int          testsFailed;
  int          seed;

  clockGen clocks (.Fphi0(Fphi0), .rst(rst));

  memModel memory (.Fphi0(Fphi0), .addr(memAddr), .rd(memRd), .data(memData));

  anticTop DUT (
    .Fphi0     (Fphi0),
    .rst       (rst),
    .dlistLoad (dlistLoad),
    .dlistAddr (dlistAddr),
    .dmactl    (dmactl),
    .chbase    (chbase),
    .vblank    (vblank),
    .memAddr   (memAddr),
    .memRd     (memRd),
    .memData   (memData),
    .lineStart (lineStart),
    .line      (line),
    .byteOut   (byteOut),
    .byteData  (byteData),
    .dli       (dli),
    .dmaBusy   (dmaBusy)
  );

  // Event monitor
  always @(posedge Fphi0) begin
    if (lineStart)
      lineQ.push_back(line);
    if (byteOut)
      byteQ.push_back(byteData);
    if (dli)
      dliCount++;
    if (memRd)
      addrQ.push_back(memAddr);
    // Busy spans the address cycle and the capture cycle of every read
    if (!rst && dmaBusy !== (memRd || prevRd))
      reportError($sformatf("dmaBusy is %b, expected %b", dmaBusy, memRd || prevRd));
    prevRd <= memRd;
  end

  function automatic lineInfo makeLine(input logic [3:0] mode, input logic [3:0] scan,
                                       input logic lms);
    return {mode, scan, lms};
  endfunction

  function automatic logic [7:0] reverseBits(input logic [7:0] b);
    logic [7:0] r;
    for (int i = 0; i < 8; i++)
      r[i] = b[7 - i];
    return r;
  endfunction

  function automatic dmaByte makeByte(input logic isGlyph, input logic [15:0] addr);
    logic [7:0] data;
    data = memory.peek(addr);
    if (isGlyph)
      data = reverseBits(data);
    return {isGlyph, addr, data};
  endfunction

  task automatic reportError(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    errors++;
  endtask

  // First byte in the top used byte of the vector
  task automatic writeList(input logic [15:0] base, input int n, input logic [63:0] bytes);
    for (int i = 0; i < n; i++)
      memory.poke(base + 16'(i), bytes[8 * (n - 1 - i) +: 8]);
  endtask

  task automatic loadList(input logic [15:0] addr);
    testStartErrors = errors;
    lineQ.delete();
    byteQ.delete();
    addrQ.delete();
    expLines.delete();
    expBytes.delete();
    expAddrs.delete();
    dliCount = 0;
    @(posedge Fphi0);
    dlistLoad <= 1'b1;
    dlistAddr <= addr;
    vblank <= 1'b1;
    @(posedge Fphi0);
    dlistLoad <= 1'b0;
    vblank <= 1'b0;
  endtask

  task automatic pulseVblank();
    @(posedge Fphi0);
    vblank <= 1'b1;
    @(posedge Fphi0);
    vblank <= 1'b0;
  endtask

  // Done once the lines are in and the engine sits idle
  task automatic waitDone(input int nLines);
    int quiet;
    quiet = 0;
    while (lineQ.size() < nLines)
      @(negedge Fphi0);
    while (quiet < 4) begin
      @(negedge Fphi0);
      if (dmaBusy)
        quiet = 0;
      else
        quiet++;
    end
  endtask

  task automatic checkResults(input string name, input int expDli, input bit checkAddrs);
    if (lineQ.size() != expLines.size())
      reportError($sformatf("%s: %0d lines, expected %0d", name, lineQ.size(),
                            expLines.size()));
    for (int i = 0; i < lineQ.size() && i < expLines.size(); i++)
      if (lineQ[i] != expLines[i])
        reportError($sformatf("%s: line %0d is %h, expected %h", name, i, lineQ[i],
                              expLines[i]));
    if (byteQ.size() != expBytes.size())
      reportError($sformatf("%s: %0d bytes, expected %0d", name, byteQ.size(),
                            expBytes.size()));
    for (int i = 0; i < byteQ.size() && i < expBytes.size(); i++)
      if (byteQ[i] != expBytes[i])
        reportError($sformatf("%s: byte %0d is %h, expected %h", name, i, byteQ[i],
                              expBytes[i]));
    if (dliCount != expDli)
      reportError($sformatf("%s: %0d dli pulses, expected %0d", name, dliCount, expDli));
    if (checkAddrs && addrQ != expAddrs)
      reportError($sformatf("%s: read addresses %p, expected %p", name, addrQ, expAddrs));
    testsRun++;
    if (errors == testStartErrors) begin
      $display("Test %s: ok", name);
    end else begin
      testsFailed++;
      $display("Test %s: %0d errors", name, errors - testStartErrors);
    end
  endtask

  task automatic testBlank();
    writeList(16'h1000, 6, 64'h00_30_70_41_00_10);
    loadList(16'h1000);
    expLines.push_back(makeLine(4'h0, 4'd0, 1'b0));
    expLines.push_back(makeLine(4'h0, 4'd3, 1'b0));
    expLines.push_back(makeLine(4'h0, 4'd7, 1'b0));
    expLines.push_back(makeLine(4'h1, 4'd0, 1'b0));
    waitDone(4);
    checkResults("blank lines", 0, 1'b0);
  endtask

  task automatic testMapLms();
    writeList(16'h1100, 6, 64'h4D_00_20_41_00_11);
    loadList(16'h1100);
    expLines.push_back(makeLine(4'hD, 4'd1, 1'b1));
    expLines.push_back(makeLine(4'h1, 4'd0, 1'b0));
    for (int i = 0; i < 40; i++)
      expBytes.push_back(makeByte(1'b0, 16'h2000 + 16'(i)));
    waitDone(2);
    checkResults("LMS map mode D", 0, 1'b0);
  endtask

  task automatic testCharMode();
    logic [7:0] code;
    writeList(16'h1200, 6, 64'h42_00_20_41_00_12);
    loadList(16'h1200);
    expLines.push_back(makeLine(4'h2, 4'd7, 1'b1));
    expLines.push_back(makeLine(4'h1, 4'd0, 1'b0));
    for (int i = 0; i < 40; i++) begin
      code = memory.peek(16'h2000 + 16'(i));
      expBytes.push_back(makeByte(1'b0, 16'h2000 + 16'(i)));
      expBytes.push_back(makeByte(1'b1, 16'(chbase) * 16'd256 + 16'(code[6:0]) * 16'd8));
    end
    waitDone(2);
    checkResults("character mode 2", 0, 1'b0);
  endtask

  task automatic testJump();
    writeList(16'h1300, 4, 64'h70_01_00_14);
    writeList(16'h1400, 4, 64'h20_41_00_13);
    loadList(16'h1300);
    expLines.push_back(makeLine(4'h0, 4'd7, 1'b0));
    expLines.push_back(makeLine(4'h1, 4'd0, 1'b0));
    expLines.push_back(makeLine(4'h0, 4'd2, 1'b0));
    expLines.push_back(makeLine(4'h1, 4'd0, 1'b0));
    for (int i = 0; i < 4; i++)
      expAddrs.push_back(16'h1300 + 16'(i));
    for (int i = 0; i < 4; i++)
      expAddrs.push_back(16'h1400 + 16'(i));
    waitDone(4);
    checkResults("JMP", 0, 1'b1);
  endtask

  task automatic testJvb();
    writeList(16'h1500, 3, 64'h41_00_16);
    writeList(16'h1600, 4, 64'h10_41_00_15);
    loadList(16'h1500);
    waitDone(1);
    repeat (20) @(negedge Fphi0);
    if (addrQ.size() != 3)
      reportError($sformatf("JVB: %0d reads before vblank, expected 3", addrQ.size()));
    pulseVblank();
    waitDone(3);
    expLines.push_back(makeLine(4'h1, 4'd0, 1'b0));
    expLines.push_back(makeLine(4'h0, 4'd1, 1'b0));
    expLines.push_back(makeLine(4'h1, 4'd0, 1'b0));
    for (int i = 0; i < 3; i++)
      expAddrs.push_back(16'h1500 + 16'(i));
    for (int i = 0; i < 4; i++)
      expAddrs.push_back(16'h1600 + 16'(i));
    checkResults("JVB and vblank", 0, 1'b1);
  endtask

  task automatic testDli();
    writeList(16'h1700, 8, 64'h80_00_CD_00_20_41_00_17);
    loadList(16'h1700);
    expLines.push_back(makeLine(4'h0, 4'd0, 1'b0));
    expLines.push_back(makeLine(4'h0, 4'd0, 1'b0));
    expLines.push_back(makeLine(4'hD, 4'd1, 1'b1));
    expLines.push_back(makeLine(4'h1, 4'd0, 1'b0));
    for (int i = 0; i < 40; i++)
      expBytes.push_back(makeByte(1'b0, 16'h2000 + 16'(i)));
    waitDone(4);
    checkResults("DLI", 2, 1'b0);
  endtask

  // Nothing may be read with the enable bit clear
  task automatic testDmaOff();
    @(posedge Fphi0);
    dmactl <= 8'h00;
    loadList(16'h1000);
    repeat (20) @(negedge Fphi0);
    checkResults("DMA disabled", 0, 1'b1);
  endtask

  initial begin
    dlistLoad = 1'b0;
    dlistAddr = 16'h0000;
    dmactl = 8'h20;
    chbase = 8'hE0;
    vblank = 1'b0;
    prevRd = 1'b0;
    errors = 0;
    testStartErrors = 0;
    testsRun = 0;
    testsFailed = 0;
    dliCount = 0;
    seed = 90335;
    @(negedge rst);
    // Random screen area
    for (int i = 0; i < 32; i++)
      memory.poke(16'h2000 + 16'(i), 8'($random(seed)));
    testBlank();
    testMapLms();
    testCharMode();
    testJump();
    testJvb();
    testDli();
    testDmaOff();
    $display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, errors);
    if (errors == 0 && testsFailed == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    #(watchdogCycles * clkPeriod);
    $display("Watchdog expired after %0d cycles, the DUT stopped responding", watchdogCycles);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== dv/clockGen.sv ====
// ******************************
// 40 ns clock; rst held for the first 4 cycles
// ******************************
`timescale 1ns/100ps

module clockGen (
  output logic Fphi0,
  output logic rst
);

  initial begin
    Fphi0 = 1'b0;
    forever #20 Fphi0 = ~Fphi0;
  end

  initial begin
    rst = 1'b1;
    repeat (4) @(posedge Fphi0);
    rst <= 1'b0;
  end

endmodule

// ==== dv/memModel.sv ====
// ******************************
// 64 KB, data one cycle after rd
// ******************************
`timescale 1ns/100ps

module memModel (
  input  logic        Fphi0,
  input  logic [15:0] addr,
  input  logic        rd,
  output logic [7:0]  data
);

  logic [7:0] mem [65536];

  // Fill depends on both address bytes
  initial begin
    for (int a = 0; a < 65536; a++)
      mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5A;
    data = 8'h00;
  end

  always @(posedge Fphi0) begin
    if (rd)
      data <= mem[addr];
  end

  task automatic poke(input logic [15:0] a, input logic [7:0] value);
    mem[a] = value;
  endtask

  function automatic logic [7:0] peek(input logic [15:0] a);
    return mem[a];
  endfunction

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module anticTb -f tb.f -o anticSim

output=$(./obj_dir/anticSim)
echo "$output"

if echo "$output" | grep -qx "PASS: all tests"; then
  exit 0
fi
exit 1

// ==== source/anticPkg.sv ====
// ******************************
// Normal playfield width only; glyph scan row 0 only
// ******************************
package anticPkg;

  // Low nibble of a display list instruction
  typedef enum logic [3:0] {
    opBlank = 4'h0,
    opJump  = 4'h1,
    opMode2 = 4'h2,
    opMode3 = 4'h3,
    opMode4 = 4'h4,
    opMode5 = 4'h5,
    opMode6 = 4'h6,
    opMode7 = 4'h7,
    opMode8 = 4'h8,
    opMode9 = 4'h9,
    opModeA = 4'hA,
    opModeB = 4'hB,
    opModeC = 4'hC,
    opModeD = 4'hD,
    opModeE = 4'hE,
    opModeF = 4'hF
  } dlOpcode;

  typedef enum logic [2:0] {
    fkNone,
    fkInstr,
    fkOperLo,
    fkOperHi,
    fkScreen,
    fkGlyph
  } fetchKind;

  typedef enum logic [1:0] {
    stIdle,
    stAddr,
    stCapture,
    stWaitVblank
  } dmaState;

  typedef struct packed {
    fetchKind   kind;
    logic [7:0] screenCode;
  } fetchReq;

  typedef struct packed {
    logic       valid;
    fetchKind   kind;
    logic [7:0] data;
  } fetchResp;

  // scanLines holds the count minus 1
  typedef struct packed {
    dlOpcode    mode;
    logic [3:0] scanLines;
    logic       lms;
  } lineInfo;

  typedef struct packed {
    logic        isGlyph;
    logic [15:0] addr;
    logic [7:0]  data;
  } dmaByte;

  localparam logic [5:0] bytesPerLine [16] = '{
    6'd0, 6'd0, 6'd40, 6'd40, 6'd40, 6'd40, 6'd20, 6'd20,
    6'd10, 6'd10, 6'd20, 6'd20, 6'd20, 6'd40, 6'd40, 6'd40
  };

  localparam logic [3:0] scanLinesPerMode [16] = '{
    4'd0, 4'd0, 4'd7, 4'd9, 4'd7, 4'd15, 4'd7, 4'd15,
    4'd7, 4'd3, 4'd3, 4'd1, 4'd0, 4'd1, 4'd0, 4'd0
  };

  // DMACTL display list DMA enable
  localparam int dmaEnBit = 5;

endpackage

// ==== source/anticTop.sv ====
// ******************************
// Display list DMA front end; no pixel path
// ******************************
`timescale 1ns/100ps

module anticTop import anticPkg::*; (
  input  logic        Fphi0,
  input  logic        rst,
  input  logic        dlistLoad,
  input  logic [15:0] dlistAddr,
  input  logic [7:0]  dmactl,
  input  logic [7:0]  chbase,
  input  logic        vblank,
  output logic [15:0] memAddr,
  output logic        memRd,
  input  logic [7:0]  memData,
  output logic        lineStart,
  output lineInfo     line,
  output logic        byteOut,
  output dmaByte      byteData,
  output logic        dli,
  output logic        dmaBusy
);

  fetchReq  req;
  fetchResp resp;
  logic     loadPtr;
  logic     loadMsr;
  logic     waitVblank;

  // A new list pointer also flushes the current instruction
  dlistDecoder decoder (
    .Fphi0      (Fphi0),
    .rst        (rst),
    .restart    (dlistLoad),
    .resp       (resp),
    .req        (req),
    .loadPtr    (loadPtr),
    .loadMsr    (loadMsr),
    .waitVblank (waitVblank),
    .lineStart  (lineStart),
    .line       (line),
    .dli        (dli)
  );

  dlistDma dma (
    .Fphi0      (Fphi0),
    .rst        (rst),
    .dlistLoad  (dlistLoad),
    .dlistAddr  (dlistAddr),
    .dmactl     (dmactl),
    .chbase     (chbase),
    .vblank     (vblank),
    .req        (req),
    .loadPtr    (loadPtr),
    .loadMsr    (loadMsr),
    .waitVblank (waitVblank),
    .resp       (resp),
    .memAddr    (memAddr),
    .memRd      (memRd),
    .memData    (memData),
    .byteOut    (byteOut),
    .byteData   (byteData),
    .dmaBusy    (dmaBusy)
  );

endmodule

// ==== source/dlistDecoder.sv ====
// ******************************
// One fetch in flight at a time; idle until the first restart
// ******************************
`timescale 1ns/100ps

module dlistDecoder import anticPkg::*; (
  input  logic     Fphi0,
  input  logic     rst,
  input  logic     restart,
  input  fetchResp resp,
  output fetchReq  req,
  output logic     loadPtr,
  output logic     loadMsr,
  output logic     waitVblank,
  output logic     lineStart,
  output lineInfo  line,
  output logic     dli
);

  logic       running;
  logic [7:0] ir;
  logic [1:0] operCnt;
  logic [5:0] screenCnt;
  logic       glyphPend;
  logic [7:0] lastCode;

  dlOpcode    irOp;
  dlOpcode    newOp;
  logic       charMode;
  logic       operHiDone;
  logic       lastFetch;
  logic       dliFlag;
  lineInfo    newLine;

  assign irOp = dlOpcode'(ir[3:0]);
  assign newOp = dlOpcode'(resp.data[3:0]);
  assign charMode = (irOp >= opMode2) && (irOp <= opMode5);

  // Operand commands go out with the high byte still on the bus
  assign operHiDone = resp.valid && (resp.kind == fkOperHi);
  assign loadPtr = operHiDone && (irOp == opJump);
  assign waitVblank = loadPtr && ir[6];
  assign loadMsr = operHiDone && (irOp != opJump);

  always_comb begin
    // Modes 2 and 3 have a 128 glyph set
    req.screenCode = lastCode;
    if (irOp == opMode2 || irOp == opMode3)
      req.screenCode = {1'b0, lastCode[6:0]};
    if (!running)
      req.kind = fkNone;
    else if (operCnt == 2'd2)
      req.kind = fkOperLo;
    else if (operCnt == 2'd1)
      req.kind = fkOperHi;
    else if (glyphPend)
      req.kind = fkGlyph;
    else if (screenCnt != 6'd0)
      req.kind = fkScreen;
    else
      req.kind = fkInstr;
  end

  always_comb begin
    lastFetch = 1'b0;
    dliFlag = ir[7];
    case (resp.kind)
      fkInstr: begin
        lastFetch = (newOp == opBlank);
        dliFlag = resp.data[7];
      end
      fkOperHi: lastFetch = (irOp == opJump);
      fkScreen: lastFetch = !charMode && (screenCnt == 6'd1);
      fkGlyph:  lastFetch = (screenCnt == 6'd0);
      default:  lastFetch = 1'b0;
    endcase
  end

  always_comb begin
    newLine.mode = newOp;
    newLine.lms = (newOp > opJump) && resp.data[6];
    if (newOp == opBlank)
      newLine.scanLines = {1'b0, resp.data[6:4]};
    else
      newLine.scanLines = scanLinesPerMode[newOp];
  end

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      running <= 1'b0;
      ir <= 8'h00;
      operCnt <= 2'd0;
      screenCnt <= 6'd0;
      glyphPend <= 1'b0;
      lineStart <= 1'b0;
      dli <= 1'b0;
    end else begin
      lineStart <= 1'b0;
      dli <= 1'b0;
      if (restart) begin
        running <= 1'b1;
        ir <= 8'h00;
        operCnt <= 2'd0;
        screenCnt <= 6'd0;
        glyphPend <= 1'b0;
      end else if (resp.valid) begin
        dli <= lastFetch && dliFlag;
        case (resp.kind)
          fkInstr: begin
            ir <= resp.data;
            screenCnt <= bytesPerLine[newOp];
            glyphPend <= 1'b0;
            lineStart <= 1'b1;
            if (newOp == opJump || newLine.lms)
              operCnt <= 2'd2;
            else
              operCnt <= 2'd0;
          end
          fkOperLo: operCnt <= 2'd1;
          fkOperHi: operCnt <= 2'd0;
          fkScreen: begin
            screenCnt <= screenCnt - 6'd1;
            glyphPend <= charMode;
          end
          fkGlyph: glyphPend <= 1'b0;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge Fphi0) begin
    if (resp.valid && resp.kind == fkScreen)
      lastCode <= resp.data;
    if (resp.valid && resp.kind == fkInstr)
      line <= newLine;
  end

  // The engine only answers fetches that were asked for
  respNeedsReq: assert property (@(posedge Fphi0) disable iff (rst)
    resp.valid |-> req.kind != fkNone);

endmodule

// ==== source/dlistDma.sv ====
// ******************************
// Memory never stalls; every access is address cycle then capture cycle
// ******************************
`timescale 1ns/100ps

module dlistDma import anticPkg::*; (
  input  logic        Fphi0,
  input  logic        rst,
  input  logic        dlistLoad,
  input  logic [15:0] dlistAddr,
  input  logic [7:0]  dmactl,
  input  logic [7:0]  chbase,
  input  logic        vblank,
  input  fetchReq     req,
  input  logic        loadPtr,
  input  logic        loadMsr,
  input  logic        waitVblank,
  output fetchResp    resp,
  output logic [15:0] memAddr,
  output logic        memRd,
  input  logic [7:0]  memData,
  output logic        byteOut,
  output dmaByte      byteData,
  output logic        dmaBusy
);

  dmaState     state;
  fetchKind    curKind;
  fetchKind    startKind;
  logic        dmaEn;
  logic        startFetch;
  logic        capture;
  logic [15:0] addrReg;
  logic [15:0] nextAddr;
  logic [15:0] listPtr;
  logic [15:0] msr;
  logic [7:0]  operLo;
  logic [7:0]  glyphBits;

  assign dmaEn = dmactl[dmaEnBit];
  assign capture = (state == stCapture);

  // A list load starts an instruction fetch in the same cycle
  assign startFetch = (state == stIdle) && dmaEn && (dlistLoad || req.kind != fkNone);
  assign startKind = dlistLoad ? fkInstr : req.kind;

  always_comb begin
    case (req.kind)
      fkScreen: nextAddr = msr;
      fkGlyph:  nextAddr = {chbase, 8'h00} + {5'd0, req.screenCode, 3'd0};
      default:  nextAddr = listPtr;
    endcase
  end

  // Character ROM bit order is the mirror of the shift order
  assign glyphBits = {<<{memData}};

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      state <= stIdle;
      curKind <= fkNone;
    end else begin
      case (state)
        stIdle: begin
          if (startFetch) begin
            curKind <= startKind;
            state <= stAddr;
          end
        end
        stAddr: state <= stCapture;
        stCapture: state <= waitVblank ? stWaitVblank : stIdle;
        stWaitVblank: begin
          if (vblank)
            state <= stIdle;
        end
        default: state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge Fphi0) begin
    if (startFetch)
      addrReg <= dlistLoad ? dlistAddr : nextAddr;
  end

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      listPtr <= 16'h0000;
      msr <= 16'h0000;
    end else begin
      if (dlistLoad)
        listPtr <= dlistAddr;
      else if (loadPtr)
        listPtr <= {memData, operLo};
      else if (capture && (curKind == fkInstr || curKind == fkOperLo ||
                           curKind == fkOperHi))
        listPtr <= listPtr + 16'd1;

      if (loadMsr)
        msr <= {memData, operLo};
      else if (capture && curKind == fkScreen)
        msr <= msr + 16'd1;
    end
  end

  always_ff @(posedge Fphi0) begin
    if (capture && curKind == fkOperLo)
      operLo <= memData;
    if (capture) begin
      byteData.isGlyph <= (curKind == fkGlyph);
      byteData.addr <= addrReg;
      byteData.data <= (curKind == fkGlyph) ? glyphBits : memData;
    end
  end

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst)
      byteOut <= 1'b0;
    else
      byteOut <= capture && (curKind == fkScreen || curKind == fkGlyph);
  end

  assign resp.valid = capture;
  assign resp.kind = curKind;
  assign resp.data = memData;

  assign memAddr = addrReg;
  assign memRd = (state == stAddr);
  assign dmaBusy = (state == stAddr) || (state == stCapture);

  // Read strobe is a single cycle and is always answered next cycle
  memRdSingle: assert property (@(posedge Fphi0) disable iff (rst)
    memRd |=> !memRd && resp.valid);

  // Only vblank releases a JVB wait
  vblankHold: assert property (@(posedge Fphi0) disable iff (rst)
    (state == stWaitVblank && !vblank) |=> state == stWaitVblank);

endmodule

// ==== tb.f ====
source/anticPkg.sv
source/dlistDecoder.sv
source/dlistDma.sv
source/anticTop.sv
dv/clockGen.sv
dv/memModel.sv
dv/anticTb.sv
